/* sources.f */
switch_pkg.sv
rx_port_fifo.sv
ingress_arbiter.sv
frame_process.sv
mac_table.sv
tx_port_queue.sv
switch_top.sv
tb_switch_top.sv

/* Makefile */
TOP = tb_switch_top

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f \
		--Mdir obj_dir -o sim
	@out="$$(./obj_dir/sim 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -q "Everything OK"

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir

/* tb_switch_top.sv */
`timescale 1ns/100ps

module tb_switch_top;
    import switch_pkg::*;

    logic      clk = 1'b0;
    logic      rst_n;
    gmii_rx_t  rx [NUM_PORTS];
    gmii_tx_t  tx [NUM_PORTS];
    port_map_t tx_en;
    logic      sent_any;

    logic [31:0] lcg_state;
    int          next_tag;
    byte_t       frame_mem [256][MAX_FRAME_BYTES];
    int          frame_len [256];
    int          exp_q [NUM_PORTS][$];
    byte_t       got [NUM_PORTS][$];
    int          batch_tag [NUM_PORTS];

    // reference copy of the learning table
    logic        ref_valid [2**HASH_BITS];
    mac_addr_t   ref_mac [2**HASH_BITS];
    port_id_t    ref_port [2**HASH_BITS];

    localparam mac_addr_t UNKNOWN_MAC = 48'h0a0b_0c0d_0e0f;
    // same index as the station on port 0
    localparam mac_addr_t CLASH_MAC   = 48'h0200_0000_0020;

    switch_top u_dut (
        .clk     (clk),
        .i_rst_n (rst_n),
        .i_rx    (rx),
        .o_tx    (tx)
    );

    always #50 clk = ~clk;

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            tx_en[p] = tx[p].en;
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic fail_value(input string name, input int got_val, input int exp_val);
        stop_run($sformatf("FAILED %s got %0h expected %0h", name, got_val, exp_val));
    endtask

    a_quiet_until_sent: assert property (@(posedge clk) disable iff (!rst_n)
        !sent_any |-> (tx_en == '0))
        else stop_run("a port transmitted before any frame was offered");

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic mac_addr_t station(input int p);
        return 48'h0200_0000_0010 + mac_addr_t'(p);
    endfunction

    function automatic hash_t mac_index(input mac_addr_t m);
        byte_t x;
        x = m[47:40] ^ m[39:32] ^ m[31:24] ^ m[23:16] ^ m[15:8] ^ m[7:0];
        return x[HASH_BITS-1:0];
    endfunction

    // lookup on the old table, then learn the source
    function automatic port_map_t model_lookup(input mac_addr_t dmac, input mac_addr_t smac,
                                               input port_id_t src);
        hash_t     dh;
        hash_t     sh;
        port_map_t src_bit;
        port_map_t map;
        dh      = mac_index(dmac);
        sh      = mac_index(smac);
        src_bit = port_map_t'(1) << src;
        if (ref_valid[dh] && ref_mac[dh] == dmac && dmac != '1) begin
            map = (port_map_t'(1) << ref_port[dh]) & ~src_bit;
        end else begin
            map = ~src_bit;
        end
        if (smac != '1) begin
            ref_valid[sh] = 1'b1;
            ref_mac[sh]   = smac;
            ref_port[sh]  = src;
        end
        return map;
    endfunction

    function automatic int build_frame(input mac_addr_t dmac, input mac_addr_t smac);
        int          tag;
        logic [31:0] r;
        tag = next_tag;
        next_tag++;
        r = lcg_next();
        frame_len[tag] = 14 + int'(r[23:16]) % 51;
        for (int i = 0; i < MAX_FRAME_BYTES; i++) begin
            r = lcg_next();
            if (i < 6) begin
                frame_mem[tag][i] = dmac[47-8*i -: 8];
            end else if (i < 12) begin
                frame_mem[tag][i] = smac[95-8*i -: 8];
            end else if (i == 12) begin
                frame_mem[tag][i] = byte_t'(tag);
            end else begin
                frame_mem[tag][i] = r[23:16];
            end
        end
        return tag;
    endfunction

    function automatic void expect_frame(input int tag, input port_map_t map);
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (map[p]) begin
                exp_q[p].push_back(tag);
            end
        end
    endfunction

    // err_at below zero gives a clean frame
    task automatic drive_frame(input int port, input int tag, input int err_at);
        sent_any = 1'b1;
        for (int i = 0; i < frame_len[tag]; i++) begin
            @(negedge clk);
            rx[port].dv   = 1'b1;
            rx[port].er   = (i == err_at);
            rx[port].data = frame_mem[tag][i];
        end
        @(negedge clk);
        rx[port] = '0;
    endtask

    task automatic send_frame(input int port, input mac_addr_t dmac, input mac_addr_t smac);
        int tag;
        tag = build_frame(dmac, smac);
        expect_frame(tag, model_lookup(dmac, smac, port_id_t'(port)));
        drive_frame(port, tag, -1);
    endtask

    function automatic logic all_done();
        logic done;
        done = 1'b1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (exp_q[p].size() != 0 || got[p].size() != 0) begin
                done = 1'b0;
            end
        end
        return done;
    endfunction

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (!all_done()) begin
            @(negedge clk);
            cycles++;
            if (cycles > 3000) begin
                stop_run("timeout while waiting for expected frames to leave the switch");
            end
        end
    endtask

    // match by tag so the order across sources does not matter
    task automatic check_frame(input int p);
        int tag;
        int pos;
        pos = -1;
        assert (got[p].size() >= 14 && got[p].size() <= MAX_FRAME_BYTES)
            else stop_run($sformatf("port %0d sent a frame of %0d bytes", p, got[p].size()));
        tag = int'(got[p][12]);
        for (int k = 0; k < exp_q[p].size(); k++) begin
            if (exp_q[p][k] == tag) begin
                pos = k;
            end
        end
        assert (pos >= 0)
            else stop_run($sformatf("port %0d sent frame with tag %0h that was not expected",
                                    p, tag));
        exp_q[p].delete(pos);
        assert (got[p].size() == frame_len[tag])
            else fail_value($sformatf("o_tx[%0d] frame length", p), got[p].size(),
                            frame_len[tag]);
        for (int i = 0; i < frame_len[tag]; i++) begin
            assert (got[p][i] == frame_mem[tag][i])
                else fail_value($sformatf("o_tx[%0d].data", p), int'(got[p][i]),
                                int'(frame_mem[tag][i]));
        end
    endtask

    always @(negedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (tx[p].en) begin
                got[p].push_back(tx[p].data);
            end else if (got[p].size() != 0) begin
                check_frame(p);
                got[p].delete();
            end
        end
    end

    initial begin
        rst_n     = 1'b0;
        sent_any  = 1'b0;
        lcg_state = 32'h7538;
        next_tag  = 1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            rx[p] = '0;
        end
        for (int i = 0; i < 2**HASH_BITS; i++) begin
            ref_valid[i] = 1'b0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (5) @(negedge clk);

        // unknown and broadcast destinations flood, stations get learned
        send_frame(0, UNKNOWN_MAC, station(0));
        wait_drain();
        for (int p = 1; p < NUM_PORTS; p++) begin
            send_frame(p, '1, station(p));
            wait_drain();
        end

        // known destination, then one back to its own port
        send_frame(1, station(0), station(1));
        wait_drain();
        send_frame(0, station(0), station(0));
        send_frame(0, station(2), station(0));
        wait_drain();

        // errored frame vanishes, the next one on that port passes
        batch_tag[0] = build_frame('1, station(2));
        drive_frame(2, batch_tag[0], 8);
        send_frame(2, station(3), station(2));
        wait_drain();

        // all four ports at once
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (p == 0) begin
                batch_tag[p] = build_frame(UNKNOWN_MAC, station(p));
                expect_frame(batch_tag[p], model_lookup(UNKNOWN_MAC, station(p), port_id_t'(p)));
            end else begin
                batch_tag[p] = build_frame(station((p + 1) % 4), station(p));
                expect_frame(batch_tag[p],
                             model_lookup(station((p + 1) % 4), station(p), port_id_t'(p)));
            end
        end
        fork
            drive_frame(0, batch_tag[0], -1);
            drive_frame(1, batch_tag[1], -1);
            drive_frame(2, batch_tag[2], -1);
            drive_frame(3, batch_tag[3], -1);
        join
        wait_drain();

        // colliding source overwrites the entry of station 0
        send_frame(3, '1, CLASH_MAC);
        wait_drain();
        send_frame(1, station(0), station(1));
        wait_drain();
        send_frame(2, CLASH_MAC, station(2));
        wait_drain();

        $display("Everything OK");
        $finish;
    end

endmodule

/* switch_top.sv */
`timescale 1ns/100ps

module switch_top (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  switch_pkg::gmii_rx_t i_rx [switch_pkg::NUM_PORTS],
    output switch_pkg::gmii_tx_t o_tx [switch_pkg::NUM_PORTS]
);
    import switch_pkg::*;

    port_map_t    frame_avail;
    port_map_t    rx_pop;
    frame_beat_t  rx_beats [NUM_PORTS];
    logic         fp_valid;
    logic         fp_ready;
    frame_beat_t  fp_beat;
    logic         lookup_req;
    lookup_req_t  lookup_q;
    logic         lookup_ack;
    lookup_resp_t lookup_resp;
    port_map_t    has_room;
    port_map_t    wr_mask;
    byte_t        wr_data;
    logic         wr_last;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_rx
        rx_port_fifo u_rx_fifo (
            .clk           (clk),
            .i_rst_n       (i_rst_n),
            .i_rx          (i_rx[p]),
            .i_port        (port_id_t'(p)),
            .i_pop         (rx_pop[p]),
            .o_frame_avail (frame_avail[p]),
            .o_beat        (rx_beats[p])
        );
    end

    ingress_arbiter u_arbiter (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_frame_avail (frame_avail),
        .i_beats       (rx_beats),
        .o_pop         (rx_pop),
        .o_valid       (fp_valid),
        .o_beat        (fp_beat),
        .i_ready       (fp_ready)
    );

    frame_process u_frame_process (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_valid      (fp_valid),
        .i_beat       (fp_beat),
        .o_ready      (fp_ready),
        .o_lookup_req (lookup_req),
        .o_lookup     (lookup_q),
        .i_lookup_ack (lookup_ack),
        .i_lookup     (lookup_resp),
        .i_has_room   (has_room),
        .o_wr_mask    (wr_mask),
        .o_wr_data    (wr_data),
        .o_wr_last    (wr_last)
    );

    mac_table u_mac_table (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_lookup_req (lookup_req),
        .i_lookup     (lookup_q),
        .o_lookup_ack (lookup_ack),
        .o_lookup     (lookup_resp)
    );

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_tx
        tx_port_queue u_tx_queue (
            .clk        (clk),
            .i_rst_n    (i_rst_n),
            .i_wr       (wr_mask[p]),
            .i_wr_data  (wr_data),
            .i_wr_last  (wr_last),
            .o_has_room (has_room[p]),
            .o_tx       (o_tx[p])
        );
    end

endmodule

/* tx_port_queue.sv */
`timescale 1ns/100ps

module tx_port_queue (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_wr,
    input  switch_pkg::byte_t    i_wr_data,
    input  logic                 i_wr_last,
    output logic                 o_has_room,
    output switch_pkg::gmii_tx_t o_tx
);
    import switch_pkg::*;

    byte_t    mem_data [TX_FIFO_BYTES];
    logic     mem_last [TX_FIFO_BYTES];
    tx_ptr_t  wr_ptr;
    tx_ptr_t  rd_ptr;
    tx_ptr_t  frame_cnt;
    logic     busy;
    logic     gap;
    logic     rd_en;
    logic     rd_last;
    gmii_tx_t tx_q;

    // keep reading inside a frame, start only on a complete one
    assign rd_en      = busy || ((frame_cnt != '0) && !gap);
    assign rd_last    = rd_en && mem_last[rd_ptr[TX_AW-1:0]];
    assign o_has_room = (wr_ptr - rd_ptr) <= tx_ptr_t'(TX_FIFO_BYTES - MAX_FRAME_BYTES);

    always_ff @(posedge clk) begin
        if (i_wr) begin
            mem_data[wr_ptr[TX_AW-1:0]] <= i_wr_data;
            mem_last[wr_ptr[TX_AW-1:0]] <= i_wr_last;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            frame_cnt <= '0;
            busy      <= 1'b0;
            gap       <= 1'b0;
            tx_q      <= '0;
        end else begin
            if (i_wr) begin
                wr_ptr <= wr_ptr + 1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1;
            end
            busy <= rd_en && !rd_last;
            // one idle cycle after each frame
            gap  <= rd_last;
            case ({i_wr && i_wr_last, rd_last})
                2'b10:   frame_cnt <= frame_cnt + 1;
                2'b01:   frame_cnt <= frame_cnt - 1;
                default: frame_cnt <= frame_cnt;
            endcase
            tx_q.en   <= rd_en;
            tx_q.data <= rd_en ? mem_data[rd_ptr[TX_AW-1:0]] : '0;
        end
    end

    assign o_tx = tx_q;

    a_no_write_full: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_wr |-> ((wr_ptr - rd_ptr) != tx_ptr_t'(TX_FIFO_BYTES)));

endmodule

/* mac_table.sv */
`timescale 1ns/100ps

module mac_table (
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  logic                     i_lookup_req,
    input  switch_pkg::lookup_req_t  i_lookup,
    output logic                     o_lookup_ack,
    output switch_pkg::lookup_resp_t o_lookup
);
    import switch_pkg::*;

    logic [2**HASH_BITS-1:0] tbl_valid;
    mac_addr_t               tbl_mac  [2**HASH_BITS];
    port_id_t                tbl_port [2**HASH_BITS];
    hash_t                   d_idx;
    hash_t                   s_idx;
    logic                    hit;
    logic                    learn;
    port_map_t               src_bit;
    port_map_t               map;
    logic                    ack_q;
    lookup_resp_t            resp_q;

    // fold the six octets together
    function automatic hash_t mac_hash(input mac_addr_t mac);
        byte_t x;
        x = '0;
        for (int k = 0; k < 6; k++) begin
            x = x ^ mac[8*k +: 8];
        end
        return x[HASH_BITS-1:0];
    endfunction

    always_comb begin
        d_idx   = mac_hash(i_lookup.dmac);
        s_idx   = mac_hash(i_lookup.smac);
        learn   = i_lookup_req && (i_lookup.smac != BCAST_MAC);
        src_bit = port_map_t'(1) << i_lookup.src_port;
        hit     = tbl_valid[d_idx] && (tbl_mac[d_idx] == i_lookup.dmac)
                  && (i_lookup.dmac != BCAST_MAC);
        if (hit) begin
            map = (port_map_t'(1) << tbl_port[d_idx]) & ~src_bit;
        end else begin
            map = ~src_bit;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            tbl_valid <= '0;
            ack_q     <= 1'b0;
        end else begin
            ack_q <= i_lookup_req;
            if (learn) begin
                tbl_valid[s_idx] <= 1'b1;
            end
        end
    end

    // map is taken from the old contents, learning lands at the same edge
    always_ff @(posedge clk) begin
        if (learn) begin
            tbl_mac[s_idx]  <= i_lookup.smac;
            tbl_port[s_idx] <= i_lookup.src_port;
        end
        if (i_lookup_req) begin
            resp_q.port_map <= map;
        end
    end

    assign o_lookup_ack = ack_q;
    assign o_lookup     = resp_q;

endmodule

/* frame_process.sv */
`timescale 1ns/100ps

module frame_process (
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  logic                     i_valid,
    input  switch_pkg::frame_beat_t  i_beat,
    output logic                     o_ready,
    output logic                     o_lookup_req,
    output switch_pkg::lookup_req_t  o_lookup,
    input  logic                     i_lookup_ack,
    input  switch_pkg::lookup_resp_t i_lookup,
    input  switch_pkg::port_map_t    i_has_room,
    output switch_pkg::port_map_t    o_wr_mask,
    output switch_pkg::byte_t        o_wr_data,
    output logic                     o_wr_last
);
    import switch_pkg::*;

    fp_state_e  state;
    byte_t      frame_buf [MAX_FRAME_BYTES];
    frame_len_t len;
    frame_len_t rd_idx;
    mac_addr_t  dmac;
    mac_addr_t  smac;
    port_id_t   src_port;
    port_map_t  port_map;
    logic       lookup_req_q;
    logic       beat_in;
    logic       room_ok;

    assign o_ready      = (state == FP_RECV);
    assign beat_in      = i_valid && o_ready;
    assign o_lookup_req = lookup_req_q;
    assign o_lookup     = '{dmac: dmac, smac: smac, src_port: src_port};

    // on the ack cycle the fresh map is checked so no cycle is lost
    assign room_ok = ((i_lookup_ack ? i_lookup.port_map : port_map) & ~i_has_room) == '0;

    always_ff @(posedge clk) begin
        if (beat_in) begin
            frame_buf[len[FRAME_AW-1:0]] <= i_beat.data;
            src_port <= i_beat.src_port;
            // bytes 0..5 then 6..11, first byte ends up on top
            if (len < 6) begin
                dmac <= {dmac[39:0], i_beat.data};
            end else if (len < 12) begin
                smac <= {smac[39:0], i_beat.data};
            end
        end
        if (i_lookup_ack) begin
            port_map <= i_lookup.port_map;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state        <= FP_RECV;
            len          <= '0;
            rd_idx       <= '0;
            lookup_req_q <= 1'b0;
        end else begin
            lookup_req_q <= 1'b0;
            case (state)
                FP_RECV: begin
                    if (beat_in) begin
                        len <= len + 1;
                        if (i_beat.last) begin
                            state        <= FP_LOOKUP;
                            lookup_req_q <= 1'b1;
                        end
                    end
                end
                FP_LOOKUP: begin
                    if (i_lookup_ack) begin
                        rd_idx <= '0;
                        // nowhere to go, drop it
                        if (i_lookup.port_map == '0) begin
                            state <= FP_RECV;
                            len   <= '0;
                        end else if (room_ok) begin
                            state <= FP_SEND;
                        end else begin
                            state <= FP_WAIT_ROOM;
                        end
                    end
                end
                FP_WAIT_ROOM: begin
                    if (room_ok) begin
                        state <= FP_SEND;
                    end
                end
                FP_SEND: begin
                    rd_idx <= rd_idx + 1;
                    if (o_wr_last) begin
                        state <= FP_RECV;
                        len   <= '0;
                    end
                end
                default: state <= FP_RECV;
            endcase
        end
    end

    always_comb begin
        o_wr_mask = (state == FP_SEND) ? port_map : '0;
        o_wr_data = frame_buf[rd_idx[FRAME_AW-1:0]];
        o_wr_last = (state == FP_SEND) && (rd_idx + 1 == len);
    end

    a_ack_after_req: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_lookup_ack |-> $past(o_lookup_req));

endmodule

/* ingress_arbiter.sv */
`timescale 1ns/100ps

module ingress_arbiter (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  switch_pkg::port_map_t   i_frame_avail,
    input  switch_pkg::frame_beat_t i_beats [switch_pkg::NUM_PORTS],
    output switch_pkg::port_map_t   o_pop,
    output logic                    o_valid,
    output switch_pkg::frame_beat_t o_beat,
    input  logic                    i_ready
);
    import switch_pkg::*;

    logic     busy;
    port_id_t owner;
    port_id_t last_winner;
    port_id_t pick;
    port_id_t cand;
    logic     found;

    // search starts one past the previous winner
    always_comb begin
        found = 1'b0;
        pick  = last_winner;
        cand  = last_winner;
        for (int k = 1; k <= NUM_PORTS; k++) begin
            cand = port_id_t'(last_winner + k);
            if (!found && i_frame_avail[cand]) begin
                found = 1'b1;
                pick  = cand;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            busy        <= 1'b0;
            owner       <= '0;
            last_winner <= port_id_t'(NUM_PORTS - 1);
        end else if (!busy) begin
            if (found) begin
                busy  <= 1'b1;
                owner <= pick;
            end
        end else if (i_ready && o_beat.last) begin
            busy        <= 1'b0;
            last_winner <= owner;
        end
    end

    assign o_valid = busy;
    assign o_beat  = i_beats[owner];
    assign o_pop   = (busy && i_ready) ? (port_map_t'(1) << owner) : '0;

    // a pop only ever goes to a port that still holds a complete frame
    a_pop_onehot: assert property (@(posedge clk) disable iff (!i_rst_n)
        $onehot0(o_pop) && ((o_pop & ~i_frame_avail) == '0));

endmodule

/* rx_port_fifo.sv */
`timescale 1ns/100ps

module rx_port_fifo (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  switch_pkg::gmii_rx_t    i_rx,
    input  switch_pkg::port_id_t    i_port,
    input  logic                    i_pop,
    output logic                    o_frame_avail,
    output switch_pkg::frame_beat_t o_beat
);
    import switch_pkg::*;

    byte_t      mem_data [RX_FIFO_BYTES];
    logic       mem_last [RX_FIFO_BYTES];
    rx_ptr_t    wr_ptr;
    rx_ptr_t    last_ptr;
    rx_ptr_t    frame_start;
    rx_ptr_t    rd_ptr;
    rx_ptr_t    frame_cnt;
    frame_len_t rx_len;
    logic       in_frame;
    logic       bad;
    logic       full;
    logic       drop_byte;
    logic       wr_en;
    logic       commit;
    logic       pop_last;

    assign full      = (wr_ptr - rd_ptr) == rx_ptr_t'(RX_FIFO_BYTES);
    // errored byte, no space left or frame too long
    assign drop_byte = i_rx.er || full || bad || (rx_len == frame_len_t'(MAX_FRAME_BYTES));
    assign wr_en     = i_rx.dv && !drop_byte;
    assign commit    = !i_rx.dv && in_frame && !bad;
    assign pop_last  = i_pop && mem_last[rd_ptr[RX_AW-1:0]];
    assign last_ptr  = wr_ptr - 1;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            wr_ptr      <= '0;
            frame_start <= '0;
            rx_len      <= '0;
            in_frame    <= 1'b0;
            bad         <= 1'b0;
        end else if (i_rx.dv) begin
            in_frame <= 1'b1;
            if (drop_byte) begin
                bad <= 1'b1;
            end else begin
                wr_ptr <= wr_ptr + 1;
                rx_len <= rx_len + 1;
            end
        end else if (in_frame) begin
            in_frame <= 1'b0;
            bad      <= 1'b0;
            rx_len   <= '0;
            // a bad frame is forgotten by rewinding
            if (bad) begin
                wr_ptr <= frame_start;
            end else begin
                frame_start <= wr_ptr;
            end
        end
    end

    // last flag goes on the previous byte once dv drops
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_data[wr_ptr[RX_AW-1:0]] <= i_rx.data;
            mem_last[wr_ptr[RX_AW-1:0]] <= 1'b0;
        end else if (commit) begin
            mem_last[last_ptr[RX_AW-1:0]] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            rd_ptr    <= '0;
            frame_cnt <= '0;
        end else begin
            if (i_pop) begin
                rd_ptr <= rd_ptr + 1;
            end
            case ({commit, pop_last})
                2'b10:   frame_cnt <= frame_cnt + 1;
                2'b01:   frame_cnt <= frame_cnt - 1;
                default: frame_cnt <= frame_cnt;
            endcase
        end
    end

    assign o_frame_avail = (frame_cnt != '0);
    assign o_beat = '{data:     mem_data[rd_ptr[RX_AW-1:0]],
                      last:     mem_last[rd_ptr[RX_AW-1:0]],
                      src_port: i_port};

    a_pop_needs_frame: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_pop |-> o_frame_avail);

endmodule

/* switch_pkg.sv */
package switch_pkg;

    localparam int NUM_PORTS       = 4;
    localparam int MAX_FRAME_BYTES = 64;
    localparam int RX_FIFO_BYTES   = 128;
    localparam int TX_FIFO_BYTES   = 128;
    localparam int HASH_BITS       = 4;

    // address widths of the byte stores
    localparam int FRAME_AW = $clog2(MAX_FRAME_BYTES);
    localparam int RX_AW    = $clog2(RX_FIFO_BYTES);
    localparam int TX_AW    = $clog2(TX_FIFO_BYTES);

    localparam logic [47:0] BCAST_MAC = 48'hffff_ffff_ffff;

    typedef logic [7:0]             byte_t;
    typedef logic [1:0]             port_id_t;
    typedef logic [NUM_PORTS-1:0]   port_map_t;
    typedef logic [47:0]            mac_addr_t;
    typedef logic [FRAME_AW:0]      frame_len_t;
    typedef logic [HASH_BITS-1:0]   hash_t;

    // one extra bit so full and empty differ
    typedef logic [RX_AW:0]         rx_ptr_t;
    typedef logic [TX_AW:0]         tx_ptr_t;

    typedef struct packed {
        logic  dv;
        logic  er;
        byte_t data;
    } gmii_rx_t;

    typedef struct packed {
        logic  en;
        byte_t data;
    } gmii_tx_t;

    typedef struct packed {
        byte_t    data;
        logic     last;
        port_id_t src_port;
    } frame_beat_t;

    typedef struct packed {
        mac_addr_t dmac;
        mac_addr_t smac;
        port_id_t  src_port;
    } lookup_req_t;

    typedef struct packed {
        port_map_t port_map;
    } lookup_resp_t;

    typedef enum logic [1:0] {
        FP_RECV,
        FP_LOOKUP,
        FP_WAIT_ROOM,
        FP_SEND
    } fp_state_e;

endpackage
